// File: rtl/rvseed_pkg.sv
`default_nettype none

package rvseed_pkg;

    localparam int XLEN           = 64;
    localparam int INST_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int SHAMT_WIDTH    = 6;                     // rv64 shifts use 6 bits

    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // funct3 / funct7 fields
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;          // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;         // sub / sra

    localparam logic [INST_WIDTH-1:0] EBREAK_INST = 32'h0010_0073;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,                               // also the reset value
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10                               // lui
    } alu_op_e;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic [REG_ADDR_WIDTH-1:0] raddr1_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] raddr2_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] waddr_i,
    input  wire logic [XLEN-1:0]           wdata_i,
    input  wire logic                      wen_i,
    output logic      [XLEN-1:0]           rdata1_o,
    output logic      [XLEN-1:0]           rdata2_o
);

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_live;

    assign wr_live = wen_i && (waddr_i != '0);           // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-first reads so a result on the write port is seen the same cycle
    assign rdata1_o = (wr_live && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (wr_live && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      inst_req_i,
    input  wire logic [INST_WIDTH-1:0]     inst_i,
    input  wire logic [XLEN-1:0]           rdata1_i,
    input  wire logic [XLEN-1:0]           rdata2_i,
    output logic                           inst_ack_o,
    output logic      [REG_ADDR_WIDTH-1:0] raddr1_o,
    output logic      [REG_ADDR_WIDTH-1:0] raddr2_o,
    output logic                           valid_o,
    output alu_op_e                        alu_op_o,
    output logic      [XLEN-1:0]           alu_src1_o,
    output logic      [XLEN-1:0]           alu_src2_o,
    output logic                           reg_wen_o,
    output logic      [REG_ADDR_WIDTH-1:0] reg_waddr_o,
    output logic                           ebreak_o,
    output logic                           illegal_o
);

    logic [XLEN-1:0] pc_q;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;

    assign valid_o = inst_req_i && !inst_ack_o;          // capture strobe

    // four-phase handshake and pc
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_ack_o <= 1'b0;
            pc_q       <= RESET_PC;
        end else if (valid_o) begin
            inst_ack_o <= 1'b1;
            pc_q       <= pc_q + XLEN'(4);
        end else if (!inst_req_i) begin
            inst_ack_o <= 1'b0;
        end
    end

    assign opcode      = inst_i[6:0];
    assign funct3      = inst_i[14:12];
    assign funct7      = inst_i[31:25];
    assign reg_waddr_o = inst_i[11:7];
    assign raddr1_o    = inst_i[19:15];
    assign raddr2_o    = inst_i[24:20];

    assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'h000};

    always_comb begin
        alu_op_o   = ALU_ADD;
        alu_src1_o = rdata1_i;
        alu_src2_o = rdata2_i;
        reg_wen_o  = 1'b0;
        ebreak_o   = 1'b0;
        illegal_o  = 1'b0;
        case (opcode)
            OP_REG: begin
                reg_wen_o = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op_o = ALU_SLL;
                    F3_SLT:     alu_op_o = ALU_SLT;
                    F3_SLTU:    alu_op_o = ALU_SLTU;
                    F3_XOR:     alu_op_o = ALU_XOR;
                    F3_SR:      alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op_o = ALU_OR;
                    F3_AND:     alu_op_o = ALU_AND;
                    default:    alu_op_o = ALU_ADD;
                endcase
                // alt funct7 only exists for sub and sra
                if (!(funct7 == F7_BASE ||
                      (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR)))) begin
                    reg_wen_o = 1'b0;
                    illegal_o = 1'b1;
                end
            end
            OP_IMM: begin
                alu_src2_o = imm_i;
                reg_wen_o  = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op_o = ALU_ADD;
                    F3_SLT:     alu_op_o = ALU_SLT;
                    F3_XOR:     alu_op_o = ALU_XOR;
                    F3_OR:      alu_op_o = ALU_OR;
                    F3_AND:     alu_op_o = ALU_AND;
                    default: begin                       // shifts-imm, sltiu not supported
                        reg_wen_o = 1'b0;
                        illegal_o = 1'b1;
                    end
                endcase
            end
            OP_LUI: begin
                alu_op_o   = ALU_PASS_B;
                alu_src2_o = imm_u;
                reg_wen_o  = 1'b1;
            end
            OP_AUIPC: begin
                alu_src1_o = pc_q;
                alu_src2_o = imm_u;
                reg_wen_o  = 1'b1;
            end
            OP_SYSTEM: begin
                ebreak_o  = (inst_i == EBREAK_INST);
                illegal_o = (inst_i != EBREAK_INST);
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/id_ex_regs.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_regs import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      valid_i,
    input  alu_op_e                        alu_op_i,
    input  wire logic [XLEN-1:0]           alu_src1_i,
    input  wire logic [XLEN-1:0]           alu_src2_i,
    input  wire logic                      reg_wen_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] reg_waddr_i,
    input  wire logic                      ebreak_i,
    input  wire logic                      illegal_i,
    output logic                           valid_o,
    output alu_op_e                        alu_op_o,
    output logic      [XLEN-1:0]           alu_src1_o,
    output logic      [XLEN-1:0]           alu_src2_o,
    output logic                           reg_wen_o,
    output logic      [REG_ADDR_WIDTH-1:0] reg_waddr_o,
    output logic                           ebreak_o,
    output logic                           illegal_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o     <= 1'b0;
            alu_op_o    <= ALU_ADD;
            alu_src1_o  <= '0;
            alu_src2_o  <= '0;
            reg_wen_o   <= 1'b0;
            reg_waddr_o <= '0;
            ebreak_o    <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            valid_o <= valid_i;                          // one-cycle slot so stale fields never replay
            if (valid_i) begin
                alu_op_o    <= alu_op_i;
                alu_src1_o  <= alu_src1_i;
                alu_src2_o  <= alu_src2_i;
                reg_wen_o   <= reg_wen_i;
                reg_waddr_o <= reg_waddr_i;
                ebreak_o    <= ebreak_i;
                illegal_o   <= illegal_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      valid_i,
    input  alu_op_e                        alu_op_i,
    input  wire logic [XLEN-1:0]           src1_i,
    input  wire logic [XLEN-1:0]           src2_i,
    input  wire logic                      reg_wen_i,
    input  wire logic [REG_ADDR_WIDTH-1:0] reg_waddr_i,
    input  wire logic                      ebreak_i,
    input  wire logic                      illegal_i,
    output logic                           wb_valid_o,
    output logic      [REG_ADDR_WIDTH-1:0] wb_addr_o,
    output logic      [XLEN-1:0]           wb_data_o,
    output logic                           ebreak_o,
    output logic                           illegal_o
);

    logic [SHAMT_WIDTH-1:0] shamt;
    logic [XLEN-1:0]        result;
    logic                   lt_signed;
    logic                   lt_unsigned;

    assign shamt       = src2_i[SHAMT_WIDTH-1:0];
    assign lt_signed   = $signed(src1_i) < $signed(src2_i);
    assign lt_unsigned = src1_i < src2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result = src1_i + src2_i;
            ALU_SUB:    result = src1_i - src2_i;
            ALU_AND:    result = src1_i & src2_i;
            ALU_OR:     result = src1_i | src2_i;
            ALU_XOR:    result = src1_i ^ src2_i;
            ALU_SLL:    result = src1_i << shamt;
            ALU_SRL:    result = src1_i >> shamt;
            ALU_SRA:    result = $unsigned($signed(src1_i) >>> shamt);
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_PASS_B: result = src2_i;
            default:    result = '0;
        endcase
    end

    // strobes pulse one cycle per executed instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_o <= 1'b0;
            ebreak_o   <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= valid_i && reg_wen_i;
            ebreak_o   <= valid_i && ebreak_i;
            illegal_o  <= valid_i && illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            wb_addr_o <= reg_waddr_i;
            wb_data_o <= result;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rvseed_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvseed_core_top import rvseed_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      inst_req_i,
    input  wire logic [INST_WIDTH-1:0]     inst_i,
    output logic                           inst_ack_o,
    output logic                           wb_valid_o,
    output logic      [REG_ADDR_WIDTH-1:0] wb_addr_o,
    output logic      [XLEN-1:0]           wb_data_o,
    output logic                           ebreak_o,
    output logic                           illegal_o
);

    logic [REG_ADDR_WIDTH-1:0] raddr1;
    logic [REG_ADDR_WIDTH-1:0] raddr2;
    logic [XLEN-1:0]           rdata1;
    logic [XLEN-1:0]           rdata2;

    // decode stage
    logic                      id_valid;
    alu_op_e                   id_alu_op;
    logic [XLEN-1:0]           id_src1;
    logic [XLEN-1:0]           id_src2;
    logic                      id_reg_wen;
    logic [REG_ADDR_WIDTH-1:0] id_reg_waddr;
    logic                      id_ebreak;
    logic                      id_illegal;

    // execute stage
    logic                      ex_valid;
    alu_op_e                   ex_alu_op;
    logic [XLEN-1:0]           ex_src1;
    logic [XLEN-1:0]           ex_src2;
    logic                      ex_reg_wen;
    logic [REG_ADDR_WIDTH-1:0] ex_reg_waddr;
    logic                      ex_ebreak;
    logic                      ex_illegal;

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .waddr_i  (wb_addr_o),                           // writeback from exec
        .wdata_i  (wb_data_o),
        .wen_i    (wb_valid_o),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    inst_decoder i_inst_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_req_i  (inst_req_i),
        .inst_i      (inst_i),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .inst_ack_o  (inst_ack_o),
        .raddr1_o    (raddr1),
        .raddr2_o    (raddr2),
        .valid_o     (id_valid),
        .alu_op_o    (id_alu_op),
        .alu_src1_o  (id_src1),
        .alu_src2_o  (id_src2),
        .reg_wen_o   (id_reg_wen),
        .reg_waddr_o (id_reg_waddr),
        .ebreak_o    (id_ebreak),
        .illegal_o   (id_illegal)
    );

    id_ex_regs i_id_ex_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (id_valid),
        .alu_op_i    (id_alu_op),
        .alu_src1_i  (id_src1),
        .alu_src2_i  (id_src2),
        .reg_wen_i   (id_reg_wen),
        .reg_waddr_i (id_reg_waddr),
        .ebreak_i    (id_ebreak),
        .illegal_i   (id_illegal),
        .valid_o     (ex_valid),
        .alu_op_o    (ex_alu_op),
        .alu_src1_o  (ex_src1),
        .alu_src2_o  (ex_src2),
        .reg_wen_o   (ex_reg_wen),
        .reg_waddr_o (ex_reg_waddr),
        .ebreak_o    (ex_ebreak),
        .illegal_o   (ex_illegal)
    );

    exec_alu i_exec_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (ex_valid),
        .alu_op_i    (ex_alu_op),
        .src1_i      (ex_src1),
        .src2_i      (ex_src2),
        .reg_wen_i   (ex_reg_wen),
        .reg_waddr_i (ex_reg_waddr),
        .ebreak_i    (ex_ebreak),
        .illegal_i   (ex_illegal),
        .wb_valid_o  (wb_valid_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o),
        .ebreak_o    (ebreak_o),
        .illegal_o   (illegal_o)
    );

endmodule

`default_nettype wire

// File: bench/rvseed_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rvseed_core_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic req_i,
    input wire logic ack_i,
    input wire logic wb_valid_i
);

    int fail_count = 0;

    ack_rise_on_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack_i) |-> $past(req_i))
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    // ack may only drop once the source has released req
    ack_hold_until_req_low: assert property (@(posedge clk) disable iff (!rst_n)
        (ack_i && req_i) |=> ack_i)
        else begin
            fail_count++;
            $error("ack dropped while req was still high");
        end

    wb_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_i |=> !wb_valid_i)
        else begin
            fail_count++;
            $error("wb_valid high for two cycles in a row");
        end

endmodule

bind rvseed_core_top rvseed_core_assert i_core_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (inst_req_i),
    .ack_i      (inst_ack_o),
    .wb_valid_i (wb_valid_o)
);

`default_nettype wire

// File: bench/tb_rvseed_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvseed_core import rvseed_pkg::*; ();

    localparam int N_IMM          = 40;
    localparam int N_REG          = 60;
    localparam int NUM_INSTS      = 3 + 30 + N_IMM + N_REG + N_REG / 10 + 7;
    localparam int TIMEOUT_CYCLES = 16 + 8 * NUM_INSTS + 64;

    localparam logic [2:0] FLAG_WB      = 3'b100;        // {wb_valid, ebreak, illegal}
    localparam logic [2:0] FLAG_EBREAK  = 3'b010;
    localparam logic [2:0] FLAG_ILLEGAL = 3'b001;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      inst_req;
    logic [INST_WIDTH-1:0]     inst_word;
    logic                      inst_ack;
    logic                      wb_valid;
    logic [REG_ADDR_WIDTH-1:0] wb_addr;
    logic [XLEN-1:0]           wb_data;
    logic                      ebreak;
    logic                      illegal;

    int seed = 32'h0a60a6f0;
    int cycles = 0;
    int issued = 0;
    int results = 0;
    int mismatches = 0;
    int other_errors = 0;

    logic [XLEN-1:0]           shadow_regs [32];
    logic [XLEN-1:0]           model_pc;
    logic [2:0]                exp_flags [$];
    logic [REG_ADDR_WIDTH-1:0] exp_addr [$];
    logic [XLEN-1:0]           exp_data [$];
    string                     exp_name [$];

    logic [9:0] reg_ops [10] = '{{F7_BASE, F3_ADD_SUB}, {F7_ALT, F3_ADD_SUB}, {F7_BASE, F3_AND},
                                 {F7_BASE, F3_OR}, {F7_BASE, F3_XOR}, {F7_BASE, F3_SLL},
                                 {F7_BASE, F3_SR}, {F7_ALT, F3_SR}, {F7_BASE, F3_SLT},
                                 {F7_BASE, F3_SLTU}};
    logic [2:0] imm_ops [5] = '{F3_ADD_SUB, F3_AND, F3_OR, F3_XOR, F3_SLT};

    rvseed_core_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req_i (inst_req),
        .inst_i     (inst_word),
        .inst_ack_o (inst_ack),
        .wb_valid_o (wb_valid),
        .wb_addr_o  (wb_addr),
        .wb_data_o  (wb_data),
        .ebreak_o   (ebreak),
        .illegal_o  (illegal)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [9:0] f7f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7f3[9:3], rs2, rs1, f7f3[2:0], rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return 5'd1 + 5'(r % 15);                        // x1..x15
    endfunction

    // expected flags, destination and value of one instruction on the shadow state
    function automatic logic [2:0] ref_model(input logic [31:0] inst,
                                             output logic [4:0] rd, output logic [XLEN-1:0] res);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_u;
        logic [2:0]      flags;
        flags = FLAG_WB;
        rd    = inst[11:7];
        a     = shadow_regs[inst[19:15]];
        b     = shadow_regs[inst[24:20]];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
        res   = '0;
        case (inst[6:0])
            OP_REG: begin
                case ({inst[31:25], inst[14:12]})
                    {F7_BASE, F3_ADD_SUB}: res = a + b;
                    {F7_ALT, F3_ADD_SUB}:  res = a - b;
                    {F7_BASE, F3_AND}:     res = a & b;
                    {F7_BASE, F3_OR}:      res = a | b;
                    {F7_BASE, F3_XOR}:     res = a ^ b;
                    {F7_BASE, F3_SLL}:     res = a << b[5:0];
                    {F7_BASE, F3_SR}:      res = a >> b[5:0];
                    {F7_ALT, F3_SR}:       res = $signed(a) >>> b[5:0];
                    {F7_BASE, F3_SLT}:     res = XLEN'($signed(a) < $signed(b));
                    {F7_BASE, F3_SLTU}:    res = XLEN'(a < b);
                    default:               flags = FLAG_ILLEGAL;
                endcase
            end
            OP_IMM: begin
                case (inst[14:12])
                    F3_ADD_SUB: res = a + imm_i;
                    F3_AND:     res = a & imm_i;
                    F3_OR:      res = a | imm_i;
                    F3_XOR:     res = a ^ imm_i;
                    F3_SLT:     res = XLEN'($signed(a) < $signed(imm_i));
                    default:    flags = FLAG_ILLEGAL;    // slli, srli, srai, sltiu
                endcase
            end
            OP_LUI:    res = imm_u;
            OP_AUIPC:  res = model_pc + imm_u;
            OP_SYSTEM: flags = (inst == EBREAK_INST) ? FLAG_EBREAK : FLAG_ILLEGAL;
            default:   flags = FLAG_ILLEGAL;
        endcase
        return flags;
    endfunction

    task automatic check_addr(input string name, input logic [REG_ADDR_WIDTH-1:0] exp,
                              input logic [REG_ADDR_WIDTH-1:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch %s wb_addr: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch %s wb_data: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch %s flags: expected %b, actual %b", name, exp, act);
        end
    endtask

    // one four-phase transfer started 1 ns after a rising edge
    task automatic issue(input string name, input logic [31:0] inst);
        logic [4:0]      rd;
        logic [XLEN-1:0] res;
        logic [2:0]      flags;
        flags = ref_model(inst, rd, res);
        exp_flags.push_back(flags);
        exp_addr.push_back(rd);
        exp_data.push_back(res);
        exp_name.push_back(name);
        if (flags == FLAG_WB && rd != 5'd0) begin
            shadow_regs[rd] = res;
        end
        model_pc = model_pc + 64'd4;
        issued++;
        inst_word = inst;
        inst_req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!inst_ack);
        inst_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (inst_ack);
    endtask

    always @(negedge clk) begin : compare_results
        string                     name;
        logic [2:0]                flags;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [XLEN-1:0]           data;
        if (rst_n && (wb_valid || ebreak || illegal)) begin
            if (exp_flags.size() == 0) begin
                other_errors++;
                $display("result pulse seen with no instruction outstanding");
            end else begin
                name  = exp_name.pop_front();
                flags = exp_flags.pop_front();
                addr  = exp_addr.pop_front();
                data  = exp_data.pop_front();
                check_flags(name, flags, {wb_valid, ebreak, illegal});
                if (flags == FLAG_WB) begin
                    check_addr(name, addr, wb_addr);
                    check_data(name, data, wb_data);
                end
                results++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d results seen", cycles, results, issued);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin : main_seq
        logic [31:0] rnd;
        logic [4:0]  rs2;
        rst_n     = 1'b0;
        inst_req  = 1'b0;
        inst_word = '0;
        model_pc  = 64'h0000_0000_8000_0000;
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flags("reset", 3'b000, {wb_valid, ebreak, illegal});
        if (inst_ack !== 1'b0) begin
            other_errors++;
            $display("inst_ack_o is not low after reset");
        end
        issue("auipc_first", enc_u(OP_AUIPC, 5'd1, 20'h00000));
        issue("auipc_next", enc_u(OP_AUIPC, 5'd2, 20'h00001));
        for (int r = 1; r < 16; r++) begin                // random register contents
            rnd = $random(seed);
            issue("lui", enc_u(OP_LUI, 5'(r), rnd[19:0]));
            issue("addi_load", enc_i(F3_ADD_SUB, 5'(r), 5'(r), rnd[31:20]));
        end
        issue("auipc_late", enc_u(OP_AUIPC, 5'd3, 20'hfffff));
        for (int i = 0; i < N_IMM; i++) begin
            rnd = $random(seed);
            issue("op_imm", enc_i(imm_ops[i % 5], pick_reg(), pick_reg(), rnd[11:0]));
        end
        for (int i = 0; i < N_REG; i++) begin
            if (i % 10 == 0) begin                        // fresh shift amount in x20
                rnd = $random(seed);
                issue("shamt", enc_i(F3_ADD_SUB, 5'd20, 5'd0, {6'd0, rnd[5:0]}));
            end
            rs2 = (i % 3 == 0) ? 5'd20 : pick_reg();
            issue("op_reg", enc_r(reg_ops[(i * 7) % 10], pick_reg(), pick_reg(), rs2));
        end
        issue("x0_write", enc_i(F3_ADD_SUB, 5'd0, 5'd5, 12'h123));
        issue("x0_read", enc_r({F7_BASE, F3_OR}, 5'd6, 5'd0, 5'd0));
        issue("x0_add", enc_r({F7_BASE, F3_ADD_SUB}, 5'd7, 5'd0, 5'd4));
        issue("ebreak", EBREAK_INST);
        issue("illegal_opcode", 32'h0000_0003);
        issue("illegal_slli", enc_i(F3_SLL, 5'd1, 5'd1, 12'd3));
        issue("after_flags", enc_r({F7_BASE, F3_ADD_SUB}, 5'd8, 5'd1, 5'd2));
        while (results < issued) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("%0d instructions, %0d mismatches, %0d other errors, %0d assertion failures",
                 issued, mismatches, other_errors, i_dut.i_core_assert.fail_count);
        if (mismatches + other_errors + i_dut.i_core_assert.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/rvseed_pkg.sv
rtl/reg_file.sv
rtl/inst_decoder.sv
rtl/id_ex_regs.sv
rtl/exec_alu.sv
rtl/rvseed_core_top.sv
bench/rvseed_core_assert.sv
bench/tb_rvseed_core.sv

// File: Bender.yml
package:
  name: rvseed_core

sources:
  - files:
      - rtl/rvseed_pkg.sv
      - rtl/reg_file.sv
      - rtl/inst_decoder.sv
      - rtl/id_ex_regs.sv
      - rtl/exec_alu.sv
      - rtl/rvseed_core_top.sv
  - target: test
    files:
      - bench/rvseed_core_assert.sv
      - bench/tb_rvseed_core.sv
